/* tb.f */
verilog/lsu_pkg.sv
verilog/store_align.sv
verilog/load_extend.sv
verilog/axil_master.sv
verilog/axil_sram.sv
verilog/lsu_top.sv
test/tb_lsu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -sv -f tb.f --top-module tb_lsu -Mdir obj_dir
	./obj_dir/Vtb_lsu | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu import lsu_pkg::*;;

    typedef struct {
        logic        write;
        logic [31:0] addr;
        mem_size_e   size;
        logic        is_unsigned;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic        from_model;
        logic        glitch;
    } entry_t;

    logic            clk;
    logic            rst;
    logic            req_valid;
    logic            req_write;
    logic [31:0]     req_addr;
    mem_size_e       req_size;
    logic            req_unsigned;
    logic [xlen-1:0] req_wdata;
    logic [xlen-1:0] rsp_rdata;
    logic            rsp_done;

    entry_t      stim_q[$];
    logic [7:0]  ref_mem [1024];
    int          errors;
    int          checks;
    int          done_count;
    logic        built;

    lsu_top #(
        .addr_width (32),
        .mem_words  (256),
        .mem_wait   (2)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_wdata    (req_wdata),
        .rsp_rdata    (rsp_rdata),
        .rsp_done     (rsp_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_store(input logic [31:0] addr, input mem_size_e size,
                             input logic [31:0] wdata, input logic glitch);
        entry_t e;
        e = '{1'b1, addr, size, 1'b0, wdata, 32'h0, 1'b0, glitch};
        stim_q.push_back(e);
    endtask

    task automatic add_load(input logic [31:0] addr, input mem_size_e size,
                            input logic is_unsigned, input logic [31:0] exp,
                            input logic glitch);
        entry_t e;
        e = '{1'b0, addr, size, is_unsigned, 32'h0, exp, 1'b0, glitch};
        stim_q.push_back(e);
    endtask

    task automatic add_random();
        entry_t e;
        e.write       = ($urandom_range(1, 0) == 1);
        e.addr        = 32'h100 + $urandom_range(31, 0);
        case ($urandom_range(2, 0))
            0: e.size = size_byte;
            1: e.size = size_half;
            default: e.size = size_word;
        endcase
        e.is_unsigned = ($urandom_range(1, 0) == 1);
        e.wdata       = $urandom;
        e.expected    = 32'h0;
        e.from_model  = 1'b1;
        e.glitch      = ($urandom_range(3, 0) == 0);
        stim_q.push_back(e);
    endtask

    // reference memory, byte addressed.
    task automatic model_store(input logic [31:0] addr, input mem_size_e size,
                               input logic [31:0] wdata);
        logic [9:0] b;
        b = addr[9:0];
        case (size)
            size_byte: begin
                ref_mem[b] = wdata[7:0];
            end
            size_half: begin
                if (!b[0]) begin
                    ref_mem[b]                = wdata[7:0];
                    ref_mem[{b[9:1], 1'b1}]   = wdata[15:8];
                end
            end
            default: begin
                if (b[1:0] == 2'b00) begin
                    ref_mem[{b[9:2], 2'd0}] = wdata[7:0];
                    ref_mem[{b[9:2], 2'd1}] = wdata[15:8];
                    ref_mem[{b[9:2], 2'd2}] = wdata[23:16];
                    ref_mem[{b[9:2], 2'd3}] = wdata[31:24];
                end
            end
        endcase
    endtask

    function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_size_e size,
                                               input logic is_unsigned);
        logic [9:0]  b;
        logic [7:0]  b8;
        logic [15:0] h16;
        logic [31:0] r;
        b = addr[9:0];
        case (size)
            size_byte: begin
                b8 = ref_mem[b];
                r  = is_unsigned ? {24'h0, b8} : {{24{b8[7]}}, b8};
            end
            size_half: begin
                // odd halfword offsets read as zero.
                h16 = b[0] ? 16'h0 : {ref_mem[{b[9:1], 1'b1}], ref_mem[b]};
                r   = is_unsigned ? {16'h0, h16} : {{16{h16[15]}}, h16};
            end
            default: begin
                r = {ref_mem[{b[9:2], 2'd3}], ref_mem[{b[9:2], 2'd2}],
                     ref_mem[{b[9:2], 2'd1}], ref_mem[{b[9:2], 2'd0}]};
            end
        endcase
        return r;
    endfunction

    // count done pulses; rdata must stay zero between them.
    always @(negedge clk) begin
        if (rsp_done === 1'b1) begin
            done_count++;
        end else if (!rst) begin
            check("rsp_rdata", rsp_rdata, 32'h0);
        end
    end

    initial begin
        wait (built);
        repeat (stim_q.size() * 40 + 20) @(posedge clk);
        $display("timeout: the DUT stopped answering before all entries were applied");
        $display("test failed");
        $finish;
    end

    initial begin
        entry_t      e;
        int          cycles;
        logic        got_done;
        logic [31:0] seen;
        logic [31:0] exp;

        errors       = 0;
        checks       = 0;
        done_count   = 0;
        built        = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = 32'h0;
        req_size     = size_byte;
        req_unsigned = 1'b0;
        req_wdata    = '0;
        void'($urandom(7));
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;
        end

        add_store(32'h100, size_word, 32'hDEADBEEF, 1'b0);
        add_load(32'h100, size_word, 1'b0, 32'hDEADBEEF, 1'b0);
        // one byte per lane with junk in the upper data bits.
        add_store(32'h104, size_byte, 32'hAAAAAA12, 1'b0);
        add_store(32'h105, size_byte, 32'h55555585, 1'b0);
        add_store(32'h106, size_byte, 32'h1234567F, 1'b0);
        add_store(32'h107, size_byte, 32'h000000F0, 1'b0);
        add_load(32'h104, size_word, 1'b0, 32'hF07F8512, 1'b0);
        add_load(32'h104, size_byte, 1'b0, 32'h00000012, 1'b0);
        add_load(32'h105, size_byte, 1'b0, 32'hFFFFFF85, 1'b0);
        add_load(32'h105, size_byte, 1'b1, 32'h00000085, 1'b0);
        add_load(32'h106, size_byte, 1'b0, 32'h0000007F, 1'b0);
        add_load(32'h106, size_byte, 1'b1, 32'h0000007F, 1'b0);
        add_load(32'h107, size_byte, 1'b0, 32'hFFFFFFF0, 1'b0);
        add_load(32'h107, size_byte, 1'b1, 32'h000000F0, 1'b0);
        add_store(32'h108, size_word, 32'h11223344, 1'b0);
        add_store(32'h108, size_half, 32'hFFFFABCD, 1'b0);
        add_load(32'h108, size_word, 1'b0, 32'h1122ABCD, 1'b0);
        add_store(32'h10A, size_half, 32'h99997654, 1'b0);
        add_load(32'h108, size_word, 1'b0, 32'h7654ABCD, 1'b0);
        add_load(32'h108, size_half, 1'b0, 32'hFFFFABCD, 1'b0);
        add_load(32'h108, size_half, 1'b1, 32'h0000ABCD, 1'b0);
        add_load(32'h10A, size_half, 1'b0, 32'h00007654, 1'b0);
        add_load(32'h10A, size_half, 1'b1, 32'h00007654, 1'b0);
        add_load(32'h109, size_half, 1'b0, 32'h00000000, 1'b0);
        add_load(32'h10B, size_half, 1'b1, 32'h00000000, 1'b0);
        // misaligned stores must leave memory alone.
        add_store(32'h109, size_half, 32'h0000FFFF, 1'b0);
        add_store(32'h10A, size_word, 32'h55555555, 1'b0);
        add_store(32'h107, size_word, 32'h01010101, 1'b0);
        add_load(32'h108, size_word, 1'b0, 32'h7654ABCD, 1'b0);
        add_load(32'h10B, size_word, 1'b0, 32'h7654ABCD, 1'b0);
        add_load(32'h105, size_word, 1'b0, 32'hF07F8512, 1'b0);
        add_load(32'h101, size_word, 1'b0, 32'hDEADBEEF, 1'b0);
        add_store(32'h10C, size_word, 32'hCAFEF00D, 1'b1);
        add_load(32'h10C, size_word, 1'b0, 32'hCAFEF00D, 1'b1);
        add_load(32'h10E, size_byte, 1'b1, 32'h000000FE, 1'b1);
        for (int i = 0; i < 40; i++) begin
            add_random();
        end
        built = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        for (int i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            check("done_count", done_count, i);
            req_write    = e.write;
            req_addr     = e.addr;
            req_size     = e.size;
            req_unsigned = e.is_unsigned;
            req_wdata    = e.wdata;
            req_valid    = 1'b1;
            cycles       = 0;
            got_done     = 1'b0;
            while (!got_done) begin
                @(negedge clk);
                cycles++;
                if (rsp_done) begin
                    got_done = 1'b1;
                end else if (e.glitch && cycles == 1) begin
                    req_valid = 1'b0;
                end else if (e.glitch && cycles == 2) begin
                    // a second edge in flight is ignored.
                    req_valid = 1'b1;
                end
            end
            seen      = rsp_rdata;
            req_valid = 1'b0;
            if (e.write) begin
                model_store(e.addr, e.size, e.wdata);
            end else begin
                exp = e.from_model ? model_load(e.addr, e.size, e.is_unsigned) : e.expected;
                check("rsp_rdata", seen, exp);
            end
            @(negedge clk);
        end

        repeat (3) @(negedge clk);
        check("done_count", done_count, stim_q.size());
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256,
    parameter int mem_wait   = 1
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_valid,
    input  logic                   req_write,
    input  logic [addr_width-1:0]  req_addr,
    input  mem_size_e              req_size,
    input  logic                   req_unsigned,
    input  logic [xlen-1:0]        req_wdata,

    output logic [xlen-1:0]        rsp_rdata,
    output logic                   rsp_done
);

    logic [xlen-1:0]        lane_data;
    logic [strb_width-1:0]  strb;

    logic                   awvalid;
    logic [addr_width-1:0]  awaddr;
    logic                   awready;
    logic                   wvalid;
    logic [xlen-1:0]        wdata;
    logic [strb_width-1:0]  wstrb;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;
    logic                   arvalid;
    logic [addr_width-1:0]  araddr;
    logic                   arready;
    logic                   rvalid;
    logic [xlen-1:0]        rdata;
    logic                   rready;

    logic [xlen-1:0]        rword;
    logic                   rdone;
    logic                   wdone;

    assign rsp_done = wdone | rdone;

    store_align u_store_align (
        .size      (req_size),
        .addr_lo   (req_addr[1:0]),
        .wdata     (req_wdata),
        .lane_data (lane_data),
        .strb      (strb)
    );

    axil_master #(
        .addr_width (addr_width)
    ) u_axil_master (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .lane_data (lane_data),
        .strb      (strb),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rready    (rready),
        .rword     (rword),
        .rdone     (rdone),
        .wdone     (wdone)
    );

    axil_sram #(
        .addr_width (addr_width),
        .mem_words  (mem_words),
        .mem_wait   (mem_wait)
    ) u_axil_sram (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rready  (rready)
    );

    load_extend u_load_extend (
        .size        (req_size),
        .is_unsigned (req_unsigned),
        .addr_lo     (req_addr[1:0]),
        .rvalid      (rdone),
        .rword       (rword),
        .result      (rsp_rdata)
    );

endmodule

`default_nettype wire

/* verilog/axil_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram import lsu_pkg::*; #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256,
    parameter int mem_wait   = 1
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   awvalid,
    input  logic [addr_width-1:0]  awaddr,
    output logic                   awready,

    input  logic                   wvalid,
    input  logic [xlen-1:0]        wdata,
    input  logic [strb_width-1:0]  wstrb,
    output logic                   wready,

    output logic                   bvalid,
    input  logic                   bready,

    input  logic                   arvalid,
    input  logic [addr_width-1:0]  araddr,
    output logic                   arready,

    output logic                   rvalid,
    output logic [xlen-1:0]        rdata,
    input  logic                   rready
);

    localparam int idx_width = $clog2(mem_words);
    localparam int cnt_width = $clog2(mem_wait + 2);

    logic [xlen-1:0]       mem [mem_words];
    logic [idx_width-1:0]  aw_idx;
    logic                  aw_held;
    logic [cnt_width-1:0]  wait_cnt;
    logic                  wait_done;
    logic                  aw_pend;
    logic                  w_pend;
    logic                  ar_pend;
    logic                  any_fire;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // a channel waits only while the slave can take it.
    assign aw_pend   = awvalid & ~aw_held & ~bvalid;
    assign w_pend    = wvalid & aw_held;
    assign ar_pend   = arvalid & ~rvalid;

    assign wait_done = (wait_cnt == cnt_width'(mem_wait));

    assign awready   = aw_pend & wait_done;
    assign wready    = w_pend & wait_done;
    assign arready   = ar_pend & wait_done;
    assign any_fire  = awready | wready | arready;

    // counts cycles since the pending valid was first seen.
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (any_fire) begin
            wait_cnt <= '0;
        end else if ((aw_pend || w_pend || ar_pend) && !wait_done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awready) begin
                aw_held <= 1'b1;
            end else if (wready) begin
                aw_held <= 1'b0;
            end

            // response stays up until the master takes it.
            if (wready) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            aw_idx <= awaddr[idx_width+1:2];
        end
        if (arready) begin
            rdata <= mem[araddr[idx_width+1:2]];
        end
    end

    // byte-masked write.
    always_ff @(posedge clk) begin
        if (wready) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wstrb[i]) begin
                    mem[aw_idx][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/axil_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_master import lsu_pkg::*; #(
    parameter int addr_width = 32
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_valid,
    input  logic                   req_write,
    input  logic [addr_width-1:0]  req_addr,
    input  logic [xlen-1:0]        lane_data,
    input  logic [strb_width-1:0]  strb,

    output logic                   awvalid,
    output logic [addr_width-1:0]  awaddr,
    input  logic                   awready,

    output logic                   wvalid,
    output logic [xlen-1:0]        wdata,
    output logic [strb_width-1:0]  wstrb,
    input  logic                   wready,

    input  logic                   bvalid,
    output logic                   bready,

    output logic                   arvalid,
    output logic [addr_width-1:0]  araddr,
    input  logic                   arready,

    input  logic                   rvalid,
    input  logic [xlen-1:0]        rdata,
    output logic                   rready,

    output logic [xlen-1:0]        rword,
    output logic                   rdone,
    output logic                   wdone
);

    logic req_valid_q;
    logic busy;
    logic start;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    // a new access is a rising edge of req_valid while idle.
    assign start   = req_valid & ~req_valid_q & ~busy;

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign ar_fire = arvalid & arready;
    assign wdone   = bvalid & bready;
    assign rdone   = rvalid & rready;

    assign rword   = rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
        end
    end

    // only one transaction in flight.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (wdone || rdone) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
        end else if (start && req_write) begin
            awvalid <= 1'b1;
        end else if (aw_fire) begin
            awvalid <= 1'b0;
        end
    end

    // data goes out after the address has been taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            wvalid <= 1'b0;
        end else if (aw_fire) begin
            wvalid <= 1'b1;
        end else if (w_fire) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bready <= 1'b0;
        end else if (wdone) begin
            bready <= 1'b0;
        end else if (bvalid) begin
            bready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (start && !req_write) begin
            arvalid <= 1'b1;
        end else if (ar_fire) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rready <= 1'b0;
        end else if (rdone) begin
            rready <= 1'b0;
        end else if (rvalid) begin
            rready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && req_write) begin
            awaddr <= req_addr;
        end
        if (start && !req_write) begin
            araddr <= req_addr;
        end
        if (aw_fire) begin
            wdata <= lane_data;
            wstrb <= strb;
        end
    end

endmodule

`default_nettype wire

/* verilog/load_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module load_extend import lsu_pkg::*; (
    input  mem_size_e        size,
    input  logic             is_unsigned,
    input  logic [1:0]       addr_lo,
    input  logic             rvalid,
    input  logic [xlen-1:0]  rword,
    output logic [xlen-1:0]  result
);

    logic [xlen-1:0] shifted;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;

    always_comb begin
        // bring the addressed lane down to bit 0.
        shifted  = rword >> {addr_lo, 3'b000};
        sel_byte = shifted[7:0];

        // halfwords only come from offset 0 or 2.
        if (addr_lo[0]) begin
            sel_half = 16'h0000;
        end else begin
            sel_half = shifted[15:0];
        end
    end

    always_comb begin
        result = '0;
        if (rvalid) begin
            case (size)
                size_byte: begin
                    if (is_unsigned) begin
                        result = {{(xlen-8){1'b0}}, sel_byte};
                    end else begin
                        result = {{(xlen-8){sel_byte[7]}}, sel_byte};
                    end
                end
                size_half: begin
                    if (is_unsigned) begin
                        result = {{(xlen-16){1'b0}}, sel_half};
                    end else begin
                        result = {{(xlen-16){sel_half[15]}}, sel_half};
                    end
                end
                default: begin
                    // word loads ignore the low address bits.
                    result = rword;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align import lsu_pkg::*; (
    input  mem_size_e              size,
    input  logic [1:0]             addr_lo,
    input  logic [xlen-1:0]        wdata,
    output logic [xlen-1:0]        lane_data,
    output logic [strb_width-1:0]  strb
);

    always_comb begin
        // move the low bytes up to the addressed lane.
        lane_data = wdata << {addr_lo, 3'b000};

        case (size)
            size_byte: begin
                strb = strb_width'(1) << addr_lo;
            end
            size_half: begin
                // odd offset is misaligned, so nothing is written.
                if (addr_lo[0]) begin
                    strb = '0;
                end else begin
                    strb = strb_width'(3) << addr_lo;
                end
            end
            size_word: begin
                if (addr_lo == 2'b00) begin
                    strb = '1;
                end else begin
                    strb = '0;
                end
            end
            default: begin
                strb = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data path is fixed at one 32-bit word.
    localparam int xlen = 32;

    // one strobe bit per byte lane.
    localparam int strb_width = xlen / 8;

    // access size as decoded from funct3[1:0].
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

endpackage

`default_nettype wire
